// File: src/udp_pkg.sv
`default_nettype none

package udp_pkg;

  localparam int UDP_HDR_LEN = 8; // Bytes in a UDP header.

  // IPv4 protocol numbers seen by this layer.
  typedef enum logic [7:0] {
    PROTO_ICMP = 8'd1,
    PROTO_TCP  = 8'd6,
    PROTO_UDP  = 8'd17
  } ip_proto_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HDR,
    RX_PAYLOAD,
    RX_DROP
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_LOAD,
    TX_HDR,
    TX_PAYLOAD
  } tx_state_e;

  // One byte beat. sof and eof only count while v is high.
  typedef struct packed {
    logic [7:0] d;
    logic       v;
    logic       sof;
    logic       eof;
  } byte_strm_t;

  // Fields taken from the IPv4 header.
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [7:0]  proto;  // Raw value, compared against ip_proto_e.
    logic [15:0] length; // IPv4 payload bytes.
  } ipv4_meta_t;

  // Wire order of the UDP header, first byte in the top bits.
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] chsum;
  } udp_hdr_t;

  typedef struct packed {
    logic [31:0] ipv4_addr;
    logic [15:0] udp_port;
  } dev_t;

  // Reply addressing from the user.
  typedef struct packed {
    logic [31:0] dst_ip;
    logic [15:0] dst_port;
    logic [15:0] src_port; // Not used, the device port goes out.
  } udp_tx_meta_t;

endpackage

`default_nettype wire

// File: src/udp_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module udp_ctrl
  import udp_pkg::*;
#(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                            clk,
  input  logic                            fsm_rst,
  input  byte_strm_t                      ip_rx,
  input  ipv4_meta_t                      ip_rx_meta,
  input  udp_hdr_t                        rx_hdr,
  input  dev_t                            dev,
  input  byte_strm_t                      udp_tx,
  input  logic                            fifo_empty,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
  output logic                            hdr_shift,
  output logic                            rx_out_en,
  output logic                            rx_err,
  output logic                            tx_load,
  output logic                            tx_hdr_en,
  output logic                            tx_pay_en,
  output logic                            fifo_rd,
  output logic                            tx_done
);

  localparam int TX_CNT_W = $clog2(FIFO_DEPTH + UDP_HDR_LEN + 1);

  rx_state_e           rx_state;
  tx_state_e           tx_state;
  logic [15:0]         rx_cnt;   // Bytes of this packet before the current beat.
  logic [15:0]         rx_len;
  logic [TX_CNT_W-1:0] tx_cnt;
  logic                hdr_done;
  logic                hdr_match;
  logic                rx_clr;
  logic                tx_clr;

  // Per-packet clears.
  assign rx_clr = fsm_rst || rx_err;
  assign tx_clr = fsm_rst || tx_done;

  assign hdr_done  = (rx_state == RX_HDR) && (rx_cnt == UDP_HDR_LEN);
  assign hdr_match = (rx_hdr.dst_port == dev.udp_port) && (ip_rx_meta.proto == PROTO_UDP);
  assign rx_len    = rx_cnt + 16'd1;

  assign hdr_shift = ip_rx.v && (((rx_state == RX_IDLE) && ip_rx.sof) ||
                                 ((rx_state == RX_HDR) && (rx_cnt < UDP_HDR_LEN)));
  assign rx_out_en = ip_rx.v && ((rx_state == RX_PAYLOAD) || (hdr_done && hdr_match));
  // Total must agree with both the UDP and the IPv4 length.
  assign rx_err    = rx_out_en && ip_rx.eof &&
                     ((rx_len != rx_hdr.length) || (rx_len != ip_rx_meta.length));

  always_ff @(posedge clk) begin
    if (rx_clr) begin
      rx_state <= RX_IDLE;
      rx_cnt   <= '0;
    end else if (ip_rx.v) begin
      rx_cnt <= rx_cnt + 16'd1;
      case (rx_state)
        RX_IDLE: begin
          rx_cnt <= 16'd1;
          if (ip_rx.sof && !ip_rx.eof) rx_state <= RX_HDR;
        end
        RX_HDR: begin
          if (ip_rx.eof) rx_state <= RX_IDLE; // Too short, nothing goes up.
          else if (hdr_done) rx_state <= hdr_match ? RX_PAYLOAD : RX_DROP;
        end
        default: begin
          if (ip_rx.eof) rx_state <= RX_IDLE;
        end
      endcase
    end
  end

  assign tx_load   = (tx_state == TX_IDLE) && udp_tx.v && udp_tx.sof;
  assign tx_hdr_en = (tx_state == TX_HDR);
  assign tx_pay_en = (tx_state == TX_PAYLOAD);
  // First read on the last header byte, so fifo data lines up with the payload.
  assign fifo_rd   = (tx_hdr_en && (tx_cnt == TX_CNT_W'(UDP_HDR_LEN - 1))) ||
                     (tx_pay_en && (fifo_count != '0));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_state <= TX_IDLE;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          if (udp_tx.v && udp_tx.sof) tx_state <= udp_tx.eof ? TX_HDR : TX_LOAD;
        end
        TX_LOAD: begin
          if (udp_tx.v && udp_tx.eof) tx_state <= TX_HDR;
        end
        TX_HDR: begin
          if (tx_cnt == TX_CNT_W'(UDP_HDR_LEN - 1)) tx_state <= TX_PAYLOAD;
        end
        TX_PAYLOAD: begin
          if (fifo_empty) tx_state <= TX_IDLE; // Last byte is on ip_tx now.
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_clr) begin
      tx_cnt  <= '0;
      tx_done <= 1'b0;
    end else begin
      if (tx_hdr_en || tx_pay_en) tx_cnt <= tx_cnt + 1'b1;
      tx_done <= tx_pay_en && fifo_empty;
    end
  end

  // User may only start a packet once the previous one is done.
  assert property (@(posedge clk) disable iff (fsm_rst)
    udp_tx.v && udp_tx.sof |-> tx_state == TX_IDLE);

  assert property (@(posedge clk) disable iff (fsm_rst)
    fifo_rd |-> !fifo_empty);

endmodule

`default_nettype wire

// File: src/udp_rx_parser.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx_parser
  import udp_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  byte_strm_t ip_rx,
  input  ipv4_meta_t ip_rx_meta,
  input  logic       hdr_shift,
  input  logic       out_en,
  input  logic       err,
  output udp_hdr_t   rx_hdr,
  output byte_strm_t udp_rx,
  output ipv4_meta_t udp_rx_meta,
  output logic       udp_rx_err
);

  // Holds the first seven header bytes. The eighth comes straight off the bus.
  logic [UDP_HDR_LEN-2:0][7:0] hdr_sr;
  logic [2:0]                  hdr_cnt;
  logic [2:0]                  hdr_idx;
  logic                        first_beat;

  assign hdr_idx    = ip_rx.sof ? 3'd0 : hdr_cnt; // Byte position within the header.
  assign first_beat = out_en && !udp_rx.v;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      hdr_cnt <= '0;
    end else if (hdr_shift) begin
      hdr_cnt <= hdr_idx + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_shift) begin
      hdr_sr <= {hdr_sr[UDP_HDR_LEN-3:0], ip_rx.d};
      if (hdr_idx == 3'(UDP_HDR_LEN - 1)) begin
        rx_hdr <= udp_hdr_t'({hdr_sr, ip_rx.d}); // Big endian fields.
      end
    end
  end

  // Payload stage, one cycle behind ip_rx.
  always_ff @(posedge clk) begin
    udp_rx.d <= ip_rx.d;
    if (fsm_rst) begin
      udp_rx.v   <= 1'b0;
      udp_rx.sof <= 1'b0;
      udp_rx.eof <= 1'b0;
      udp_rx_err <= 1'b0;
    end else begin
      udp_rx.v   <= out_en;
      udp_rx.sof <= first_beat;
      udp_rx.eof <= out_en && ip_rx.eof;
      udp_rx_err <= err; // Same cycle as udp_rx eof.
    end
  end

  // Kept until the next accepted packet.
  always_ff @(posedge clk) begin
    if (first_beat) udp_rx_meta <= ip_rx_meta;
  end

endmodule

`default_nettype wire

// File: src/udp_tx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                            clk,
  input  logic                            fsm_rst,
  input  logic                            wr,
  input  logic [7:0]                      wdata,
  input  logic                            rd,
  output logic [7:0]                      rdata,
  output logic                            empty,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);

  localparam int AW    = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [7:0]    mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wdata;
    if (do_rd) rdata <= mem[rd_ptr]; // Valid the cycle after rd.
  end

  // Payload longer than the buffer.
  assert property (@(posedge clk) disable iff (fsm_rst) wr |-> !full);

endmodule

`default_nettype wire

// File: src/udp_tx_framer.sv
`timescale 1ns/100ps
`default_nettype none

module udp_tx_framer
  import udp_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  input  dev_t         dev,
  input  udp_tx_meta_t udp_tx_meta,
  input  logic         load,
  input  logic         hdr_en,
  input  logic         pay_en,
  input  logic [15:0]  pay_len,
  input  logic [7:0]   fifo_rdata,
  output byte_strm_t   ip_tx,
  output ipv4_meta_t   ip_tx_meta
);

  logic [31:0]                 dst_ip_q;
  logic [15:0]                 dst_port_q;
  logic [15:0]                 len_q;
  logic [15:0]                 udp_len;
  udp_hdr_t                    tx_hdr;
  logic [UDP_HDR_LEN-2:0][7:0] hdr_sr; // Header bytes 1 to 7.
  logic                        hdr_en_q;
  logic                        first;
  logic [15:0]                 pay_left;
  logic                        last;
  logic [7:0]                  tx_d;

  // Payload size is final once the user eof has been written.
  assign first   = hdr_en && !hdr_en_q;
  assign udp_len = first ? pay_len + 16'(UDP_HDR_LEN) : len_q;
  assign last    = (pay_left == 16'd1);

  assign tx_hdr = '{
    src_port: dev.udp_port,
    dst_port: dst_port_q,
    length:   udp_len,
    chsum:    16'h0000      // Zero means no checksum in IPv4.
  };

  always_ff @(posedge clk) begin
    if (load) begin
      dst_ip_q   <= udp_tx_meta.dst_ip;
      dst_port_q <= udp_tx_meta.dst_port;
    end
    if (first) begin
      len_q  <= udp_len;
      hdr_sr <= tx_hdr[8*UDP_HDR_LEN-9:0];
    end else if (hdr_en) begin
      hdr_sr <= {hdr_sr[UDP_HDR_LEN-3:0], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      hdr_en_q <= 1'b0;
      pay_left <= '0;
    end else begin
      hdr_en_q <= hdr_en;
      if (first) pay_left <= pay_len;
      else if (pay_en) pay_left <= pay_left - 16'd1;
    end
  end

  // Byte 0 bypasses the register, it is sent in the load cycle of hdr_sr.
  assign tx_d = !hdr_en ? fifo_rdata :
                first   ? tx_hdr.src_port[15:8] : hdr_sr[UDP_HDR_LEN-2];

  assign ip_tx = '{
    d:   tx_d,
    v:   hdr_en || pay_en,
    sof: first,
    eof: pay_en && last
  };

  assign ip_tx_meta = '{
    src_ip: dev.ipv4_addr,
    dst_ip: dst_ip_q,
    proto:  PROTO_UDP,
    length: udp_len
  };

endmodule

`default_nettype wire

// File: src/udp_engine.sv
`timescale 1ns/100ps
`default_nettype none

module udp_engine
  import udp_pkg::*;
#(
  parameter int FIFO_DEPTH = 64
) (
  input  logic         clk,
  input  logic         fsm_rst,
  input  byte_strm_t   ip_rx,
  input  ipv4_meta_t   ip_rx_meta,
  output byte_strm_t   udp_rx,
  output udp_hdr_t     udp_rx_hdr,
  output ipv4_meta_t   udp_rx_meta,
  output logic         udp_rx_err,
  input  byte_strm_t   udp_tx,
  input  udp_tx_meta_t udp_tx_meta,
  output byte_strm_t   ip_tx,
  output ipv4_meta_t   ip_tx_meta,
  output logic         udp_tx_done,
  input  dev_t         dev
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic             hdr_shift;
  logic             rx_out_en;
  logic             rx_err;
  logic             tx_load;
  logic             tx_hdr_en;
  logic             tx_pay_en;
  logic             fifo_rd;
  logic             fifo_empty;
  logic [CNT_W-1:0] fifo_count;
  logic [7:0]       fifo_rdata;

  udp_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_udp_ctrl (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .ip_rx      (ip_rx),
    .ip_rx_meta (ip_rx_meta),
    .rx_hdr     (udp_rx_hdr),
    .dev        (dev),
    .udp_tx     (udp_tx),
    .fifo_empty (fifo_empty),
    .fifo_count (fifo_count),
    .hdr_shift  (hdr_shift),
    .rx_out_en  (rx_out_en),
    .rx_err     (rx_err),
    .tx_load    (tx_load),
    .tx_hdr_en  (tx_hdr_en),
    .tx_pay_en  (tx_pay_en),
    .fifo_rd    (fifo_rd),
    .tx_done    (udp_tx_done)
  );

  udp_rx_parser u_udp_rx_parser (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .ip_rx       (ip_rx),
    .ip_rx_meta  (ip_rx_meta),
    .hdr_shift   (hdr_shift),
    .out_en      (rx_out_en),
    .err         (rx_err),
    .rx_hdr      (udp_rx_hdr),
    .udp_rx      (udp_rx),
    .udp_rx_meta (udp_rx_meta),
    .udp_rx_err  (udp_rx_err)
  );

  udp_tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_udp_tx_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (udp_tx.v),
    .wdata   (udp_tx.d),
    .rd      (fifo_rd),
    .rdata   (fifo_rdata),
    .empty   (fifo_empty),
    .count   (fifo_count)
  );

  udp_tx_framer u_udp_tx_framer (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .udp_tx_meta (udp_tx_meta),
    .load        (tx_load),
    .hdr_en      (tx_hdr_en),
    .pay_en      (tx_pay_en),
    .pay_len     (16'(fifo_count)), // Fill level is the payload size during the header.
    .fifo_rdata  (fifo_rdata),
    .ip_tx       (ip_tx),
    .ip_tx_meta  (ip_tx_meta)
  );

endmodule

`default_nettype wire

// File: tests/tb_udp_tasks.svh
function automatic byte_q_t random_payload(input int n);
  byte_q_t q;
  for (int i = 0; i < n; i++) q.push_back(8'($random(seed)));
  return q;
endfunction

function automatic udp_hdr_t make_udp_hdr(input logic [15:0] dst_port, input int len);
  udp_hdr_t h;
  h.src_port = 16'($random(seed));
  h.dst_port = dst_port;
  h.length   = 16'(len);
  h.chsum    = 16'($random(seed)); // Passed up unchecked.
  return h;
endfunction

function automatic ipv4_meta_t make_ip_meta(input logic [7:0] proto, input int len);
  return '{src_ip: 32'h0a00_0001, dst_ip: dev.ipv4_addr, proto: proto, length: 16'(len)};
endfunction

// Header bytes go out big endian, then the payload.
task automatic drive_rx_packet(input udp_hdr_t hdr, input ipv4_meta_t meta,
                               input byte_q_t pay, output int first_cyc);
  byte_q_t pkt;
  pkt = pay;
  for (int j = UDP_HDR_LEN - 1; j >= 0; j--) pkt.push_front(hdr[8*(UDP_HDR_LEN-1-j) +: 8]);
  @(negedge clk);
  first_cyc  = cyc;
  ip_rx_meta = meta;
  foreach (pkt[i]) begin
    ip_rx = '{d: pkt[i], v: 1'b1, sof: (i == 0), eof: (i == pkt.size() - 1)};
    @(negedge clk);
  end
  ip_rx      = '0;
  ip_rx_meta = '0; // Metadata is only valid from sof to eof.
endtask

task automatic rx_packet(input udp_hdr_t hdr, input ipv4_meta_t meta, input int n,
                         input bit accept, input bit bad_len);
  byte_q_t    pay;
  int         start;
  int         pulses;
  beat_rec_t  rec;
  byte_strm_t exp;
  pay = random_payload(n);
  rx_q.delete();
  pulses = err_pulses;
  drive_rx_packet(hdr, meta, pay, start);
  repeat (3) @(negedge clk);
  if (!accept) pay.delete(); // Dropped, nothing may come out.
  foreach (pay[k]) begin
    exp = '{d: pay[k], v: 1'b1, sof: (k == 0), eof: (k == n - 1)};
    if (rx_q.size() == 0) begin
      log_error($sformatf("udp_rx stopped after %0d of %0d payload bytes", k, n));
      break;
    end
    rec = rx_q.pop_front();
    compare_beat(rec.b, exp, $sformatf("udp_rx byte %0d", k));
    expect_pulse(rec.err, bad_len && (k == n - 1), $sformatf("udp_rx_err at byte %0d", k));
    if (rec.cyc != start + UDP_HDR_LEN + 1 + k) begin
      log_error($sformatf("udp_rx byte %0d came in cycle %0d, not %0d", k, rec.cyc,
                          start + UDP_HDR_LEN + 1 + k));
    end
  end
  if (rx_q.size() != 0) log_error($sformatf("%0d unexpected udp_rx beats", rx_q.size()));
  expect_pulse(err_pulses != pulses, bad_len, "udp_rx_err pulse seen");
  if (accept) begin
    check_header(udp_rx_hdr, hdr, "udp_rx_hdr");
    match_meta(udp_rx_meta, meta, "udp_rx_meta");
  end
endtask

// Called on a falling edge. Drives at once so back-to-back packets follow done.
task automatic tx_packet(input int n);
  byte_q_t      pay;
  udp_tx_meta_t meta;
  udp_hdr_t     hdr;
  ipv4_meta_t   exp_meta;
  beat_rec_t    rec;
  byte_strm_t   exp;
  int           eof_cyc;
  int           waited;
  pay           = random_payload(n);
  meta.dst_ip   = $random(seed);
  meta.dst_port = 16'($random(seed));
  meta.src_port = 16'hbeef;
  hdr      = '{src_port: dev.udp_port, dst_port: meta.dst_port, length: 16'(n + 8), chsum: '0};
  exp_meta = '{src_ip: dev.ipv4_addr, dst_ip: meta.dst_ip, proto: PROTO_UDP, length: 16'(n + 8)};
  tx_q.delete();
  tx_meta_q.delete();
  done_q.delete();
  udp_tx_meta = meta;
  foreach (pay[i]) begin
    udp_tx  = '{d: pay[i], v: 1'b1, sof: (i == 0), eof: (i == n - 1)};
    eof_cyc = cyc;
    @(negedge clk);
    udp_tx_meta = '0; // Only the sof beat carries the reply address.
  end
  udp_tx = '0;
  waited = 0;
  while (done_q.size() == 0 && waited < n + 20) begin
    @(negedge clk);
    waited++;
  end
  if (done_q.size() == 0) begin
    log_error($sformatf("udp_tx_done never came for a %0d byte payload", n));
    return;
  end
  if (done_q[0] != eof_cyc + n + 9) begin
    log_error($sformatf("udp_tx_done in cycle %0d, not %0d", done_q[0], eof_cyc + n + 9));
  end
  for (int i = 0; i < n + UDP_HDR_LEN; i++) begin
    exp.d   = (i < UDP_HDR_LEN) ? hdr[8*(UDP_HDR_LEN-1-i) +: 8] : pay[i-UDP_HDR_LEN];
    exp.v   = 1'b1;
    exp.sof = (i == 0);
    exp.eof = (i == n + UDP_HDR_LEN - 1);
    if (tx_q.size() == 0) begin
      log_error($sformatf("ip_tx stopped after %0d of %0d bytes", i, n + UDP_HDR_LEN));
      break;
    end
    rec = tx_q.pop_front();
    compare_beat(rec.b, exp, $sformatf("ip_tx byte %0d", i));
    if (rec.cyc != eof_cyc + 1 + i) begin
      log_error($sformatf("ip_tx byte %0d in cycle %0d, not %0d", i, rec.cyc, eof_cyc + 1 + i));
    end
  end
  if (tx_q.size() != 0) log_error($sformatf("%0d unexpected ip_tx beats", tx_q.size()));
  if (tx_meta_q.size() == 0) log_error("ip_tx_meta was never seen with ip_tx valid");
  foreach (tx_meta_q[i]) begin
    match_meta(tx_meta_q[i], exp_meta, $sformatf("ip_tx_meta at byte %0d", i));
  end
endtask

task automatic rx_accept();
  rx_packet(make_udp_hdr(dev.udp_port, pkt_len[0] + 8), make_ip_meta(PROTO_UDP, pkt_len[0] + 8),
            pkt_len[0], 1'b1, 1'b0);
endtask

task automatic rx_drop();
  rx_packet(make_udp_hdr(dev.udp_port + 16'd1, pkt_len[1] + 8), // Wrong port.
            make_ip_meta(PROTO_UDP, pkt_len[1] + 8), pkt_len[1], 1'b0, 1'b0);
  rx_packet(make_udp_hdr(dev.udp_port, pkt_len[2] + 8), make_ip_meta(PROTO_TCP, pkt_len[2] + 8),
            pkt_len[2], 1'b0, 1'b0);
  rx_packet(make_udp_hdr(dev.udp_port, pkt_len[3] + 8), make_ip_meta(PROTO_UDP, pkt_len[3] + 8),
            pkt_len[3], 1'b1, 1'b0);
endtask

task automatic rx_len_error();
  rx_packet(make_udp_hdr(dev.udp_port, pkt_len[4] + 9), make_ip_meta(PROTO_UDP, pkt_len[4] + 8),
            pkt_len[4], 1'b1, 1'b1);
  // UDP length right, IPv4 length one short.
  rx_packet(make_udp_hdr(dev.udp_port, pkt_len[10] + 8),
            make_ip_meta(PROTO_UDP, pkt_len[10] + 7), pkt_len[10], 1'b1, 1'b1);
endtask

task automatic tx_framing();
  tx_packet(pkt_len[5]);
endtask

task automatic tx_back_to_back();
  udp_hdr_t   hdr;
  ipv4_meta_t meta;
  hdr  = make_udp_hdr(dev.udp_port, pkt_len[9] + 8);
  meta = make_ip_meta(PROTO_UDP, pkt_len[9] + 8);
  fork
    begin
      tx_packet(pkt_len[6]);
      tx_packet(pkt_len[7]);
      tx_packet(pkt_len[8]);
    end
    begin
      repeat (4) @(negedge clk); // Lands inside the first transmit.
      rx_packet(hdr, meta, pkt_len[9], 1'b1, 1'b0);
    end
  join
endtask

// File: tests/tb_udp_engine.sv
`timescale 1ns/100ps
`default_nettype none

module tb_udp_engine
  import udp_pkg::*;
();

  localparam int FIFO_DEPTH = 64;
  localparam int N_PKT      = 11; // Seven receive and four transmit packets.

  typedef logic [7:0] byte_q_t [$];

  typedef struct {
    byte_strm_t b;
    logic       err;
    int         cyc;
  } beat_rec_t;

  logic         clk;
  logic         fsm_rst;
  byte_strm_t   ip_rx;
  ipv4_meta_t   ip_rx_meta;
  byte_strm_t   udp_rx;
  udp_hdr_t     udp_rx_hdr;
  ipv4_meta_t   udp_rx_meta;
  logic         udp_rx_err;
  byte_strm_t   udp_tx;
  udp_tx_meta_t udp_tx_meta;
  byte_strm_t   ip_tx;
  ipv4_meta_t   ip_tx_meta;
  logic         udp_tx_done;
  dev_t         dev;

  integer       seed = 79696;
  int           errors;
  int           cyc;
  int           err_pulses;
  int           pkt_len [N_PKT];
  beat_rec_t    rx_q [$];
  beat_rec_t    tx_q [$];
  ipv4_meta_t   tx_meta_q [$];
  int           done_q [$];

  udp_engine #(.FIFO_DEPTH(FIFO_DEPTH)) u_udp_engine (.*);

  always #2 clk = ~clk;

  // Outputs logged with the index of the cycle they were valid in.
  always @(posedge clk) begin
    if (udp_rx.v) rx_q.push_back('{udp_rx, udp_rx_err, cyc});
    if (udp_rx_err) err_pulses++;
    if (ip_tx.v) tx_q.push_back('{ip_tx, 1'b0, cyc});
    if (ip_tx.v) tx_meta_q.push_back(ip_tx_meta);
    if (udp_tx_done) done_q.push_back(cyc);
    cyc++;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  task automatic compare_beat(input byte_strm_t got, input byte_strm_t exp, input string what);
    if (got !== exp) begin
      log_error($sformatf("%s d/v/sof/eof %h/%b%b%b, expected %h/%b%b%b", what,
                          got.d, got.v, got.sof, got.eof, exp.d, exp.v, exp.sof, exp.eof));
    end
  endtask

  task automatic check_header(input udp_hdr_t got, input udp_hdr_t exp, input string what);
    if (got !== exp) log_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic match_meta(input ipv4_meta_t got, input ipv4_meta_t exp, input string what);
    if (got !== exp) log_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic expect_pulse(input logic got, input logic exp, input string what);
    if (got !== exp) log_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic run_watchdog(input int limit_ns);
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the run is stopped", limit_ns);
    $display("TEST FAILED");
    $finish;
  endtask

  `include "tb_udp_tasks.svh"

  initial begin
    int total;
    total       = 0;
    clk         = 1'b0;
    fsm_rst     = 1'b1;
    ip_rx       = '0;
    ip_rx_meta  = '0;
    udp_tx      = '0;
    udp_tx_meta = '0;
    dev         = '{ipv4_addr: 32'hc0a8_0a02, udp_port: 16'd5005};
    for (int i = 0; i < N_PKT; i++) begin
      pkt_len[i] = 1 + ($unsigned($random(seed)) % 32);
      total += pkt_len[i];
    end
    fork
      run_watchdog((total + 40 * N_PKT) * 4);
    join_none
    repeat (3) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    expect_pulse(udp_rx.v, 1'b0, "udp_rx.v after reset");
    expect_pulse(ip_tx.v, 1'b0, "ip_tx.v after reset");
    expect_pulse(udp_rx_err, 1'b0, "udp_rx_err after reset");
    expect_pulse(udp_tx_done, 1'b0, "udp_tx_done after reset");
    rx_accept();
    rx_drop();
    rx_len_error();
    tx_framing();
    tx_back_to_back();
    repeat (4) @(negedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: udp_engine.f
+incdir+tests
src/udp_pkg.sv
src/udp_ctrl.sv
src/udp_rx_parser.sv
src/udp_tx_fifo.sv
src/udp_tx_framer.sv
src/udp_engine.sv
tests/tb_udp_engine.sv

// File: Bender.yml
package:
  name: udp_engine

sources:
  - src/udp_pkg.sv
  - src/udp_ctrl.sv
  - src/udp_rx_parser.sv
  - src/udp_tx_fifo.sv
  - src/udp_tx_framer.sv
  - src/udp_engine.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_udp_engine.sv
